// ==== common/mem_params.svh ====
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Byte address width on the master buses.
`define MEM_ADDR_W 24

// Word width everywhere.
`define MEM_DATA_W 32

// Byte enables per word.
`define MEM_BE_W (`MEM_DATA_W / 8)

// Word address width at the SRAM pins.
`define SRAM_ADDR_W 20

// Byte address bit that picks the extended bank.
`define MEM_BANK_BIT 22

`endif

// ==== common/mem_bus_pkg.sv ====
package mem_bus_pkg;

    // Master identity at the arbiter.
    typedef enum logic {
        MASTER_I = 1'b0, // Instruction bus.
        MASTER_D = 1'b1  // Data bus.
    } master_e;

    // Byte-lane converter states.
    // A partial write walks idle, fetch-old, then store-merged.
    typedef enum logic [1:0] {
        CONV_IDLE  = 2'd0, // Pass-through.
        CONV_FETCH = 2'd1, // Reading the old word.
        CONV_STORE = 2'd2  // Writing the merged word.
    } conv_state_e;

endpackage

// ==== common/sram_pkg.sv ====
package sram_pkg;

    // Pin sequencer phases of one word access.
    typedef enum logic [1:0] {
        PH_IDLE   = 2'd0,
        PH_SETUP  = 2'd1, // Address and chip enable settle.
        PH_STROBE = 2'd2  // OE or WE low.
    } sram_phase_e;

    // Selected by the bank bit of the byte address.
    typedef enum logic {
        BANK_BASE = 1'b0,
        BANK_EXT  = 1'b1
    } sram_bank_e;

endpackage

// ==== hdl/bytes_conv.sv ====
`timescale 1ns/100ps
`include "mem_params.svh"

module bytes_conv import mem_bus_pkg::*; (
    input  wire                     clk,
    input  wire                     arst_n_i,

    input  wire [`MEM_ADDR_W-1:0]   addr_i,
    input  wire [`MEM_BE_W-1:0]     be_i,
    input  wire [`MEM_DATA_W-1:0]   wdata_i,
    input  wire                     rd_i,
    input  wire                     wr_i,
    output logic [`MEM_DATA_W-1:0]  rdata_o,
    output logic                    stall_o,

    output logic [`MEM_ADDR_W-1:0]  mem_addr_o,
    output logic [`MEM_DATA_W-1:0]  mem_wdata_o,
    output logic                    mem_rd_o,
    output logic                    mem_wr_o,
    input  wire [`MEM_DATA_W-1:0]   mem_rdata_i,
    input  wire                     mem_stall_i
);

    conv_state_e            state_q;
    conv_state_e            state_d;
    logic [`MEM_DATA_W-1:0] old_q;
    logic [`MEM_DATA_W-1:0] merged;
    logic                   partial;

    assign partial = wr_i && (be_i != {`MEM_BE_W{1'b1}});

    assign mem_addr_o = addr_i;
    assign rdata_o    = mem_rdata_i;

    // New bytes where enabled, old bytes elsewhere.
    always_comb begin
        for (int k = 0; k < `MEM_BE_W; k++) begin
            merged[8*k +: 8] = be_i[k] ? wdata_i[8*k +: 8] : old_q[8*k +: 8];
        end
    end

    always_comb begin
        state_d     = state_q;
        mem_rd_o    = rd_i;
        mem_wr_o    = wr_i;
        mem_wdata_o = wdata_i;
        stall_o     = mem_stall_i;
        case (state_q)
            CONV_IDLE: begin
                if (partial) begin
                    mem_rd_o = 1'b1; // Fetch starts right away.
                    mem_wr_o = 1'b0;
                    stall_o  = 1'b1;
                    state_d  = mem_stall_i ? CONV_FETCH : CONV_STORE;
                end
            end
            CONV_FETCH: begin
                mem_rd_o = 1'b1;
                mem_wr_o = 1'b0;
                stall_o  = 1'b1;
                if (!mem_stall_i) begin
                    state_d = CONV_STORE;
                end
            end
            CONV_STORE: begin
                mem_rd_o    = 1'b0;
                mem_wr_o    = 1'b1;
                mem_wdata_o = merged;
                if (!mem_stall_i) begin
                    state_d = CONV_IDLE; // Master released here.
                end
            end
            default: state_d = CONV_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= CONV_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_d == CONV_STORE && state_q != CONV_STORE) begin
            old_q <= mem_rdata_i;
        end
    end

endmodule

// ==== ram/ram_arbiter.sv ====
`timescale 1ns/100ps
`include "mem_params.svh"

module ram_arbiter import mem_bus_pkg::*; (
    input  wire                     clk,
    input  wire                     arst_n_i,

    input  wire [`MEM_ADDR_W-1:0]   i_addr_i,
    input  wire                     i_rd_i,
    output logic [`MEM_DATA_W-1:0]  i_rdata_o,
    output logic                    i_stall_o,

    input  wire [`MEM_ADDR_W-1:0]   d_addr_i,
    input  wire [`MEM_DATA_W-1:0]   d_wdata_i,
    input  wire                     d_rd_i,
    input  wire                     d_wr_i,
    output logic [`MEM_DATA_W-1:0]  d_rdata_o,
    output logic                    d_stall_o,

    output logic                    phy_start_o,
    output logic                    phy_write_o,
    output logic [`MEM_ADDR_W-3:0]  phy_addr_o,
    output logic [`MEM_DATA_W-1:0]  phy_wdata_o,
    input  wire                     phy_done_i,
    input  wire [`MEM_DATA_W-1:0]   phy_rdata_i
);

    logic                   busy_q;
    master_e                owner_q;
    master_e                last_q;
    master_e                grant;
    logic                   i_req;
    logic                   d_req;
    logic                   i_done;
    logic                   d_done;
    logic [`MEM_DATA_W-1:0] i_hold_q;
    logic [`MEM_DATA_W-1:0] d_hold_q;

    assign i_req = i_rd_i;
    assign d_req = d_rd_i || d_wr_i;

    // Alternate on contention, else serve whoever asks.
    always_comb begin
        if (i_req && d_req) begin
            grant = (last_q == MASTER_I) ? MASTER_D : MASTER_I;
        end else if (d_req) begin
            grant = MASTER_D;
        end else begin
            grant = MASTER_I;
        end
    end

    assign phy_start_o = !busy_q && (i_req || d_req);
    assign phy_write_o = (grant == MASTER_D) && d_wr_i;
    assign phy_wdata_o = d_wdata_i;

    always_comb begin
        if (grant == MASTER_D) begin
            phy_addr_o = d_addr_i[`MEM_ADDR_W-1:2]; // Word address.
        end else begin
            phy_addr_o = i_addr_i[`MEM_ADDR_W-1:2];
        end
    end

    assign i_done = busy_q && (owner_q == MASTER_I) && phy_done_i;
    assign d_done = busy_q && (owner_q == MASTER_D) && phy_done_i;

    assign i_stall_o = i_req && !i_done;
    assign d_stall_o = d_req && !d_done;

    // Fresh word in the done cycle, last word afterwards.
    assign i_rdata_o = i_done ? phy_rdata_i : i_hold_q;
    assign d_rdata_o = d_done ? phy_rdata_i : d_hold_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q  <= 1'b0;
            owner_q <= MASTER_I;
            last_q  <= MASTER_D;
        end else if (phy_start_o) begin
            busy_q  <= 1'b1;
            owner_q <= grant;
        end else if (busy_q && phy_done_i) begin
            busy_q <= 1'b0;
            last_q <= owner_q; // Next contention goes the other way.
        end
    end

    always_ff @(posedge clk) begin
        if (i_done) begin
            i_hold_q <= phy_rdata_i;
        end
        if (d_done) begin
            d_hold_q <= phy_rdata_i;
        end
    end

endmodule

// ==== ram/sram_phy.sv ====
`timescale 1ns/100ps
`include "mem_params.svh"

module sram_phy import sram_pkg::*; (
    input  wire                      clk,
    input  wire                      arst_n_i,
    input  wire                      start_i,
    input  wire                      write_i,
    input  wire [`MEM_ADDR_W-3:0]    addr_i,
    input  wire [`MEM_DATA_W-1:0]    wdata_i,
    output logic                     done_o,
    output logic [`MEM_DATA_W-1:0]   rdata_o,

    output logic [`SRAM_ADDR_W-1:0]  base_ram_addr_o,
    output logic                     base_ram_ce_n_o,
    output logic                     base_ram_oe_n_o,
    output logic                     base_ram_we_n_o,
    inout  wire  [`MEM_DATA_W-1:0]   base_ram_data_io,

    output logic [`SRAM_ADDR_W-1:0]  ext_ram_addr_o,
    output logic                     ext_ram_ce_n_o,
    output logic                     ext_ram_oe_n_o,
    output logic                     ext_ram_we_n_o,
    inout  wire  [`MEM_DATA_W-1:0]   ext_ram_data_io
);

    sram_phase_e              phase_q;
    sram_bank_e               bank_q;
    logic                     write_q;
    logic [`SRAM_ADDR_W-1:0]  addr_q;
    logic [`MEM_DATA_W-1:0]   wdata_q;
    logic                     strobe;
    logic                     base_sel;
    logic                     ext_sel;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            phase_q <= PH_IDLE;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (phase_q)
                PH_IDLE: begin
                    if (start_i) begin
                        phase_q <= PH_SETUP;
                    end
                end
                PH_SETUP: phase_q <= PH_STROBE;
                PH_STROBE: begin
                    phase_q <= PH_IDLE;
                    done_o  <= 1'b1; // Word captured this edge.
                end
                default: phase_q <= PH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase_q == PH_IDLE && start_i) begin
            bank_q  <= addr_i[`MEM_BANK_BIT-2] ? BANK_EXT : BANK_BASE;
            addr_q  <= addr_i[`SRAM_ADDR_W-1:0];
            write_q <= write_i;
            wdata_q <= wdata_i;
        end
        if (strobe) begin
            rdata_o <= (bank_q == BANK_EXT) ? ext_ram_data_io : base_ram_data_io;
        end
    end

    assign strobe   = (phase_q == PH_STROBE);
    assign base_sel = (phase_q != PH_IDLE) && (bank_q == BANK_BASE);
    assign ext_sel  = (phase_q != PH_IDLE) && (bank_q == BANK_EXT);

    assign base_ram_addr_o  = addr_q;
    assign base_ram_ce_n_o  = !base_sel;
    assign base_ram_oe_n_o  = !(base_sel && strobe && !write_q);
    assign base_ram_we_n_o  = !(base_sel && strobe && write_q);
    assign base_ram_data_io = (base_sel && strobe && write_q) ? wdata_q : 'z;

    assign ext_ram_addr_o  = addr_q;
    assign ext_ram_ce_n_o  = !ext_sel;
    assign ext_ram_oe_n_o  = !(ext_sel && strobe && !write_q);
    assign ext_ram_we_n_o  = !(ext_sel && strobe && write_q);
    assign ext_ram_data_io = (ext_sel && strobe && write_q) ? wdata_q : 'z;

endmodule

// ==== hdl/mem_subsys_top.sv ====
`timescale 1ns/100ps
`include "mem_params.svh"

module mem_subsys_top (
    input  wire                     clk,
    input  wire                     arst_n_i,

    input  wire [`MEM_ADDR_W-1:0]   ibus_addr_i,
    input  wire                     ibus_rd_i,
    output wire [`MEM_DATA_W-1:0]   ibus_rdata_o,
    output wire                     ibus_stall_o,

    input  wire [`MEM_ADDR_W-1:0]   dbus_addr_i,
    input  wire [`MEM_BE_W-1:0]     dbus_be_i,
    input  wire [`MEM_DATA_W-1:0]   dbus_wdata_i,
    input  wire                     dbus_rd_i,
    input  wire                     dbus_wr_i,
    output wire [`MEM_DATA_W-1:0]   dbus_rdata_o,
    output wire                     dbus_stall_o,

    output wire [`SRAM_ADDR_W-1:0]  base_ram_addr_o,
    output wire                     base_ram_ce_n_o,
    output wire                     base_ram_oe_n_o,
    output wire                     base_ram_we_n_o,
    inout  wire [`MEM_DATA_W-1:0]   base_ram_data_io,

    output wire [`SRAM_ADDR_W-1:0]  ext_ram_addr_o,
    output wire                     ext_ram_ce_n_o,
    output wire                     ext_ram_oe_n_o,
    output wire                     ext_ram_we_n_o,
    inout  wire [`MEM_DATA_W-1:0]   ext_ram_data_io
);

    wire [`MEM_ADDR_W-1:0]  conv_addr;
    wire [`MEM_DATA_W-1:0]  conv_wdata;
    wire [`MEM_DATA_W-1:0]  conv_rdata;
    wire                    conv_rd;
    wire                    conv_wr;
    wire                    conv_stall;

    wire                    phy_start;
    wire                    phy_write;
    wire [`MEM_ADDR_W-3:0]  phy_addr;
    wire [`MEM_DATA_W-1:0]  phy_wdata;
    wire                    phy_done;
    wire [`MEM_DATA_W-1:0]  phy_rdata;

    bytes_conv u_bytes_conv (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .addr_i      (dbus_addr_i),
        .be_i        (dbus_be_i),
        .wdata_i     (dbus_wdata_i),
        .rd_i        (dbus_rd_i),
        .wr_i        (dbus_wr_i),
        .rdata_o     (dbus_rdata_o),
        .stall_o     (dbus_stall_o),
        .mem_addr_o  (conv_addr),
        .mem_wdata_o (conv_wdata),
        .mem_rd_o    (conv_rd),
        .mem_wr_o    (conv_wr),
        .mem_rdata_i (conv_rdata),
        .mem_stall_i (conv_stall)
    );

    // Full words only from here on.
    ram_arbiter u_ram_arbiter (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .i_addr_i    (ibus_addr_i),
        .i_rd_i      (ibus_rd_i),
        .i_rdata_o   (ibus_rdata_o),
        .i_stall_o   (ibus_stall_o),
        .d_addr_i    (conv_addr),
        .d_wdata_i   (conv_wdata),
        .d_rd_i      (conv_rd),
        .d_wr_i      (conv_wr),
        .d_rdata_o   (conv_rdata),
        .d_stall_o   (conv_stall),
        .phy_start_o (phy_start),
        .phy_write_o (phy_write),
        .phy_addr_o  (phy_addr),
        .phy_wdata_o (phy_wdata),
        .phy_done_i  (phy_done),
        .phy_rdata_i (phy_rdata)
    );

    sram_phy u_sram_phy (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .start_i          (phy_start),
        .write_i          (phy_write),
        .addr_i           (phy_addr),
        .wdata_i          (phy_wdata),
        .done_o           (phy_done),
        .rdata_o          (phy_rdata),
        .base_ram_addr_o  (base_ram_addr_o),
        .base_ram_ce_n_o  (base_ram_ce_n_o),
        .base_ram_oe_n_o  (base_ram_oe_n_o),
        .base_ram_we_n_o  (base_ram_we_n_o),
        .base_ram_data_io (base_ram_data_io),
        .ext_ram_addr_o   (ext_ram_addr_o),
        .ext_ram_ce_n_o   (ext_ram_ce_n_o),
        .ext_ram_oe_n_o   (ext_ram_oe_n_o),
        .ext_ram_we_n_o   (ext_ram_we_n_o),
        .ext_ram_data_io  (ext_ram_data_io)
    );

endmodule

// ==== tests/sram_model.sv ====
`timescale 1ns/100ps
`include "mem_params.svh"

module sram_model #(
    parameter logic bank_id = 1'b0
) (
    input  wire [`SRAM_ADDR_W-1:0] addr_i,
    input  wire                    ce_n_i,
    input  wire                    oe_n_i,
    input  wire                    we_n_i,
    inout  wire [`MEM_DATA_W-1:0]  data_io
);

    logic [`MEM_DATA_W-1:0] mem [0:(1 << `SRAM_ADDR_W)-1];

    // Power-up fill built from bank and word address.
    initial begin
        for (int a = 0; a < (1 << `SRAM_ADDR_W); a++) begin
            mem[a] = {7'h35, bank_id, 4'h0, a[19:0]};
        end
    end

    assign data_io = (!ce_n_i && !oe_n_i && we_n_i) ? mem[addr_i] : 'z;

    // Write data sampled once the strobe has settled.
    always @(negedge we_n_i) begin
        #1;
        if (!ce_n_i && !we_n_i) begin
            mem[addr_i] = data_io;
        end
    end

endmodule

// ==== tests/tb_mem_subsys.sv ====
`timescale 1ns/100ps
`include "mem_params.svh"

module tb_mem_subsys;

    localparam int TIMEOUT_CYCLES = 20000; // Several times the summed test length.

    logic                    clk;
    logic                    arst_n_i;
    logic [`MEM_ADDR_W-1:0]  ibus_addr_i;
    logic                    ibus_rd_i;
    logic [`MEM_ADDR_W-1:0]  dbus_addr_i;
    logic [`MEM_BE_W-1:0]    dbus_be_i;
    logic [`MEM_DATA_W-1:0]  dbus_wdata_i;
    logic                    dbus_rd_i;
    logic                    dbus_wr_i;
    wire  [`MEM_DATA_W-1:0]  ibus_rdata_o;
    wire  [`MEM_DATA_W-1:0]  dbus_rdata_o;
    wire                     ibus_stall_o;
    wire                     dbus_stall_o;
    wire  [`SRAM_ADDR_W-1:0] base_ram_addr_o;
    wire  [`SRAM_ADDR_W-1:0] ext_ram_addr_o;
    wire                     base_ram_ce_n_o;
    wire                     base_ram_oe_n_o;
    wire                     base_ram_we_n_o;
    wire                     ext_ram_ce_n_o;
    wire                     ext_ram_oe_n_o;
    wire                     ext_ram_we_n_o;
    wire  [`MEM_DATA_W-1:0]  base_ram_data_io;
    wire  [`MEM_DATA_W-1:0]  ext_ram_data_io;

    logic [31:0] lcg_state = 32'hb620;
    int          cycle_cnt = 0;
    logic [31:0] ref_mem [0:(1 << 21)-1]; // Bank bit and word address.

    mem_subsys_top u_mem_subsys_top (.*);

    sram_model #(.bank_id(1'b0)) u_base_ram (.addr_i(base_ram_addr_o), .ce_n_i(base_ram_ce_n_o),
        .oe_n_i(base_ram_oe_n_o), .we_n_i(base_ram_we_n_o), .data_io(base_ram_data_io));
    sram_model #(.bank_id(1'b1)) u_ext_ram (.addr_i(ext_ram_addr_o), .ce_n_i(ext_ram_ce_n_o),
        .oe_n_i(ext_ram_oe_n_o), .we_n_i(ext_ram_we_n_o), .data_io(ext_ram_data_io));

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles without finishing the tests", cycle_cnt);
            $display("Test failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Uses the high LCG bits.
    function automatic logic [`MEM_ADDR_W-1:0] rand_addr();
        logic [31:0] r;
        r = next_rand();
        return {1'b0, r[31:11], 2'b00};
    endfunction

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // One access per port at once, both checked against the reference.
    task automatic run_pair(input logic i_en, input logic [23:0] i_addr, input logic d_rd,
            input logic d_wr, input logic [23:0] d_addr, input logic [3:0] d_be,
            input logic [31:0] d_wdata);
        logic [31:0] i_exp;
        logic [31:0] d_exp;
        logic        i_busy;
        logic        d_busy;
        logic        i_fin;
        logic        d_fin;
        i_exp        = ref_mem[i_addr[22:2]];
        d_exp        = ref_mem[d_addr[22:2]];
        i_busy       = i_en;
        d_busy       = d_rd || d_wr;
        ibus_addr_i  = i_addr;
        ibus_rd_i    = i_en;
        dbus_addr_i  = d_addr;
        dbus_be_i    = d_be;
        dbus_wdata_i = d_wdata;
        dbus_rd_i    = d_rd;
        dbus_wr_i    = d_wr;
        while (i_busy || d_busy) begin
            #1; // Settled value for the coming rising edge.
            i_fin = i_busy && !ibus_stall_o;
            d_fin = d_busy && !dbus_stall_o;
            if (i_fin) begin
                check_word(ibus_rdata_o, i_exp, "ibus read data");
            end
            if (d_fin && d_rd) begin
                check_word(dbus_rdata_o, d_exp, "dbus read data");
            end
            @(negedge clk);
            i_busy    = i_busy && !i_fin;
            d_busy    = d_busy && !d_fin;
            ibus_rd_i = i_busy;
            dbus_rd_i = d_busy && d_rd;
            dbus_wr_i = d_busy && d_wr;
        end
        if (d_wr) begin
            for (int k = 0; k < 4; k++) begin
                if (d_be[k]) begin
                    d_exp[8*k +: 8] = d_wdata[8*k +: 8];
                end
            end
            ref_mem[d_addr[22:2]] = d_exp;
        end
    endtask

    // One port holds a read while the other keeps reading back to back.
    task automatic hold_against_stream(input logic i_holds, input logic [23:0] held_addr,
            input logic [23:0] other_addr);
        logic [31:0] held_exp;
        logic [31:0] other_exp;
        logic        held_fin;
        logic        other_fin;
        int          waits;
        held_exp    = ref_mem[held_addr[22:2]];
        other_exp   = ref_mem[other_addr[22:2]];
        held_fin    = 1'b0;
        waits       = 0;
        ibus_addr_i = i_holds ? held_addr : other_addr;
        dbus_addr_i = i_holds ? other_addr : held_addr;
        dbus_be_i   = 4'hf;
        ibus_rd_i   = 1'b1;
        dbus_rd_i   = 1'b1;
        dbus_wr_i   = 1'b0;
        while (!held_fin) begin
            #1;
            held_fin  = i_holds ? !ibus_stall_o : !dbus_stall_o;
            other_fin = i_holds ? !dbus_stall_o : !ibus_stall_o;
            if (held_fin) begin
                check_word(i_holds ? ibus_rdata_o : dbus_rdata_o, held_exp, "held read data");
            end
            if (other_fin) begin
                check_word(i_holds ? dbus_rdata_o : ibus_rdata_o, other_exp,
                    "streamed read data");
                waits++;
                check_word(waits > 1, 1'b0, "held port waited on more than one access");
            end
            @(negedge clk);
        end
        ibus_rd_i = 1'b0;
        dbus_rd_i = 1'b0;
    endtask

    task automatic test_reset();
        check_word({base_ram_ce_n_o, base_ram_oe_n_o, base_ram_we_n_o,
            ext_ram_ce_n_o, ext_ram_oe_n_o, ext_ram_we_n_o}, 32'h3f, "SRAM strobes after reset");
        check_word({ibus_stall_o, dbus_stall_o}, 32'h0, "stalls after reset");
    endtask

    task automatic test_full_words();
        logic [23:0] a;
        for (int b = 0; b < 2; b++) begin
            a     = rand_addr();
            a[22] = b[0];
            run_pair(1'b0, '0, 1'b0, 1'b1, a, 4'hf, next_rand());
            run_pair(1'b1, a, 1'b1, 1'b0, a, 4'hf, '0);
            check_word(b ? u_ext_ram.mem[a[21:2]] : u_base_ram.mem[a[21:2]],
                ref_mem[a[22:2]], "word in the selected bank");
            check_word(b ? u_base_ram.mem[a[21:2]] : u_ext_ram.mem[a[21:2]],
                ref_mem[{~a[22], a[21:2]}], "word in the other bank");
        end
    endtask

    task automatic test_partial();
        logic [23:0] be_set = 24'hc3_8421; // Single lanes, then lane pairs.
        logic [23:0] a;
        a = rand_addr();
        run_pair(1'b0, '0, 1'b0, 1'b1, a, 4'hf, next_rand());
        for (int k = 0; k < 6; k++) begin
            run_pair(1'b0, '0, 1'b0, 1'b1, a, be_set[4*k +: 4], next_rand());
            run_pair(1'b0, '0, 1'b1, 1'b0, a, 4'hf, '0);
        end
    endtask

    task automatic test_contention();
        logic [23:0] a;
        logic [23:0] b;
        a = rand_addr();
        b = a ^ 24'h40_0004; // Other bank, other word.
        run_pair(1'b0, '0, 1'b0, 1'b1, b, 4'hf, next_rand());
        run_pair(1'b1, a, 1'b1, 1'b0, b, 4'hf, '0);
        run_pair(1'b1, b, 1'b0, 1'b1, a, 4'hf, next_rand());
        run_pair(1'b1, a, 1'b0, 1'b1, b, 4'h6, next_rand());
        hold_against_stream(1'b1, a, b);
        hold_against_stream(1'b0, a, b);
    endtask

    task automatic test_random();
        logic [31:0] r;
        logic [23:0] ia;
        logic [23:0] da;
        repeat (200) begin
            r  = next_rand();
            ia = rand_addr();
            da = rand_addr();
            if (ia[22:2] == da[22:2]) begin
                ia[3] = ~ia[3]; // Keeps the ports on different words.
            end
            run_pair(r[31], ia, r[30] && !r[29], r[29], da, r[27:24], next_rand());
        end
    endtask

    initial begin
        clk          = 1'b0;
        arst_n_i     = 1'b0;
        ibus_addr_i  = '0;
        ibus_rd_i    = 1'b0;
        dbus_addr_i  = '0;
        dbus_be_i    = '0;
        dbus_wdata_i = '0;
        dbus_rd_i    = 1'b0;
        dbus_wr_i    = 1'b0;
        for (int k = 0; k < (1 << 21); k++) begin
            ref_mem[k] = {7'h35, k[20], 4'h0, k[19:0]};
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        test_reset();
        test_full_words();
        test_partial();
        test_contention();
        test_random();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+common
common/mem_bus_pkg.sv
common/sram_pkg.sv
hdl/bytes_conv.sv
ram/ram_arbiter.sv
ram/sram_phy.sv
hdl/mem_subsys_top.sv
tests/sram_model.sv
tests/tb_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - include_dirs:
      - common
    files:
      - common/mem_bus_pkg.sv
      - common/sram_pkg.sv
      - hdl/bytes_conv.sv
      - ram/ram_arbiter.sv
      - ram/sram_phy.sv
      - hdl/mem_subsys_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/sram_model.sv
      - tests/tb_mem_subsys.sv
